// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file geometry
`define CPU_XLEN      32
`define CPU_REG_W     5
`define CPU_NREGS     32
`define CPU_LINK_REG  31   // written by jal

// opcodes, instr[31:27]
`define OP_RTYPE  5'b00000
`define OP_J      5'b00001
`define OP_BNE    5'b00010
`define OP_JAL    5'b00011
`define OP_JR     5'b00100
`define OP_ADDI   5'b00101
`define OP_BLT    5'b00110
`define OP_SW     5'b00111
`define OP_LW     5'b01000

// R-type alu op field, instr[6:2]
`define ALU_ADD  5'b00000
`define ALU_SUB  5'b00001
`define ALU_AND  5'b00010
`define ALU_OR   5'b00011
`define ALU_SLL  5'b00100
`define ALU_SRA  5'b00101

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]  word_t;
    typedef logic [`CPU_REG_W-1:0] reg_idx_t;

    typedef enum logic [4:0] {
        ALU_OP_ADD = `ALU_ADD,
        ALU_OP_SUB = `ALU_SUB,
        ALU_OP_AND = `ALU_AND,
        ALU_OP_OR  = `ALU_OR,
        ALU_OP_SLL = `ALU_SLL,
        ALU_OP_SRA = `ALU_SRA
    } alu_op_e;

    // none must stay zero so that a cleared ctrl is a nop
    typedef enum logic [2:0] {
        BR_NONE,
        BR_J,
        BR_JAL,
        BR_JR,
        BR_BNE,
        BR_BLT
    } branch_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;   // operand b is the immediate
        logic     is_load;
        logic     is_store;
        branch_e  branch;
        logic     reg_wr;
        reg_idx_t rd;        // also the store data register
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;        // rt for R-type, rd otherwise
        word_t    a;
        word_t    b;
        word_t    imm;
        logic [4:0] shamt;
        word_t    target;
    } dx_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t o;
        word_t b;
    } xm_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t o;
        word_t d;
    } mw_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  wren;
    } dmem_req_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

// ==== decode/decode_stage.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decode_stage (
    input  logic              clock,
    input  logic              reset_i,
    input  cpu_pkg::fd_t      fd_i,
    input  logic              flush_i,
    input  cpu_pkg::ctrl_t    dx_ctrl_i,
    input  cpu_pkg::word_t    rdata_a_i,
    input  cpu_pkg::word_t    rdata_b_i,
    output cpu_pkg::reg_idx_t raddr_a_o,
    output cpu_pkg::reg_idx_t raddr_b_o,
    output logic              stall_o,
    output cpu_pkg::dx_t      dx_o
);
    import cpu_pkg::*;

    logic [4:0] opcode;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   src2;
    ctrl_t      ctrl;
    dx_t        dx_q;

    assign opcode = fd_i.instr[31:27];
    assign rd     = fd_i.instr[26:22];
    assign rs     = fd_i.instr[21:17];
    assign src2   = (opcode == `OP_RTYPE) ? fd_i.instr[16:12] : rd;   // rd carries sw/branch data

    always_comb begin
        ctrl    = '0;
        ctrl.rd = rd;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.alu_op = alu_op_e'(fd_i.instr[6:2]);
                ctrl.reg_wr = 1'b1;
            end
            `OP_ADDI: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_wr  = 1'b1;
            end
            `OP_LW: begin
                ctrl.use_imm = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.reg_wr  = 1'b1;
            end
            `OP_SW: begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
            end
            `OP_J:   ctrl.branch = BR_J;
            `OP_JR:  ctrl.branch = BR_JR;
            `OP_JAL: begin
                ctrl.branch = BR_JAL;
                ctrl.reg_wr = 1'b1;
                ctrl.rd     = reg_idx_t'(`CPU_LINK_REG);
            end
            `OP_BNE: begin
                ctrl.alu_op = ALU_OP_SUB;    // compare by subtraction
                ctrl.branch = BR_BNE;
            end
            `OP_BLT: begin
                ctrl.alu_op = ALU_OP_SUB;
                ctrl.branch = BR_BLT;
            end
            default: ctrl = '0;              // unknown opcode decodes as nop
        endcase
    end

    // store data is bypassed in memory, so sw only waits on its base register
    assign stall_o = dx_ctrl_i.is_load && (dx_ctrl_i.rd != '0) &&
                     ((dx_ctrl_i.rd == rs) || ((dx_ctrl_i.rd == src2) && !ctrl.is_store));

    assign raddr_a_o = rs;
    assign raddr_b_o = src2;

    always_ff @(posedge clock) begin
        if (reset_i || flush_i || stall_o) begin
            dx_q <= '0;                      // bubble
        end else begin
            dx_q.pc     <= fd_i.pc;
            dx_q.ctrl   <= ctrl;
            dx_q.rs     <= rs;
            dx_q.rt     <= src2;
            dx_q.a      <= rdata_a_i;
            dx_q.b      <= rdata_b_i;
            dx_q.imm    <= {{15{fd_i.instr[16]}}, fd_i.instr[16:0]};
            dx_q.shamt  <= fd_i.instr[11:7];
            dx_q.target <= {{5{fd_i.instr[26]}}, fd_i.instr[26:0]};
        end
    end

    assign dx_o = dx_q;

    // a stalled instruction stays in FD for the retry
    a_stall_holds_fd: assert property (
        @(posedge clock) disable iff (reset_i) (stall_o && !flush_i) |=> $stable(fd_i)
    );

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core (
    input  logic                clock,
    input  logic                reset_i,
    input  cpu_pkg::word_t      instr_i,
    input  cpu_pkg::word_t      dmem_rdata_i,
    output cpu_pkg::word_t      imem_addr_o,
    output cpu_pkg::dmem_req_t  dmem_req_o
);
    import cpu_pkg::*;

    fd_t      fd;
    dx_t      dx;
    xm_t      xm;
    mw_t      mw;
    wb_t      wb;
    logic     stall;
    logic     jump_en;
    word_t    jump_pc;
    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;

    fetch_stage i_fetch (
        .clock       (clock),
        .reset_i     (reset_i),
        .stall_i     (stall),
        .jump_en_i   (jump_en),
        .jump_pc_i   (jump_pc),
        .instr_i     (instr_i),
        .imem_addr_o (imem_addr_o),
        .fd_o        (fd)
    );

    decode_stage i_decode (
        .clock     (clock),
        .reset_i   (reset_i),
        .fd_i      (fd),
        .flush_i   (jump_en),
        .dx_ctrl_i (dx.ctrl),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .raddr_a_o (raddr_a),
        .raddr_b_o (raddr_b),
        .stall_o   (stall),
        .dx_o      (dx)
    );

    execute_stage i_execute (
        .clock     (clock),
        .reset_i   (reset_i),
        .dx_i      (dx),
        .xm_fwd_i  (xm),
        .wb_i      (wb),
        .jump_en_o (jump_en),
        .jump_pc_o (jump_pc),
        .xm_o      (xm)
    );

    memory_stage i_memory (
        .clock        (clock),
        .reset_i      (reset_i),
        .xm_i         (xm),
        .wb_i         (wb),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .mw_o         (mw)
    );

    writeback_regfile i_regfile (
        .clock     (clock),
        .reset_i   (reset_i),
        .mw_i      (mw),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb_o      (wb)
    );

endmodule

// ==== design/writeback_regfile.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module writeback_regfile (
    input  logic              clock,
    input  logic              reset_i,
    input  cpu_pkg::mw_t      mw_i,
    input  cpu_pkg::reg_idx_t raddr_a_i,
    input  cpu_pkg::reg_idx_t raddr_b_i,
    output cpu_pkg::word_t    rdata_a_o,
    output cpu_pkg::word_t    rdata_b_o,
    output cpu_pkg::wb_t      wb_o
);
    import cpu_pkg::*;

    word_t regs [`CPU_NREGS];
    wb_t   wb;

    // r0 is never written, so it reads as zero
    assign wb.we   = mw_i.ctrl.reg_wr && (mw_i.ctrl.rd != '0);
    assign wb.rd   = mw_i.ctrl.rd;
    assign wb.data = mw_i.ctrl.is_load ? mw_i.d : mw_i.o;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign rdata_a_o = (wb.we && wb.rd == raddr_a_i) ? wb.data : regs[raddr_a_i];
    assign rdata_b_o = (wb.we && wb.rd == raddr_b_i) ? wb.data : regs[raddr_b_i];

    assign wb_o = wb;

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic           clock,
    input  logic           reset_i,
    input  cpu_pkg::dx_t   dx_i,
    input  cpu_pkg::xm_t   xm_fwd_i,
    input  cpu_pkg::wb_t   wb_i,
    output logic           jump_en_o,
    output cpu_pkg::word_t jump_pc_o,
    output cpu_pkg::xm_t   xm_o
);
    import cpu_pkg::*;

    word_t a_fwd;
    word_t b_fwd;
    word_t alu_x;
    word_t alu_y;
    word_t alu_res;
    word_t result;
    logic  is_cmp;
    logic  ne;
    logic  lt;
    xm_t   xm_q;

    // newest producer wins; a load in XM has no data yet
    function automatic word_t bypass(input reg_idx_t src, input word_t reg_val);
        word_t val;
        val = reg_val;
        if (src != '0) begin
            if (xm_fwd_i.ctrl.reg_wr && !xm_fwd_i.ctrl.is_load && xm_fwd_i.ctrl.rd == src) begin
                val = xm_fwd_i.o;
            end else if (wb_i.we && wb_i.rd == src) begin
                val = wb_i.data;
            end
        end
        return val;
    endfunction

    assign a_fwd = bypass(dx_i.rs, dx_i.a);
    assign b_fwd = bypass(dx_i.rt, dx_i.b);

    // branches subtract rs from rd
    assign is_cmp = (dx_i.ctrl.branch == BR_BNE) || (dx_i.ctrl.branch == BR_BLT);
    assign alu_x  = is_cmp ? b_fwd : a_fwd;
    assign alu_y  = is_cmp ? a_fwd : (dx_i.ctrl.use_imm ? dx_i.imm : b_fwd);

    always_comb begin
        case (dx_i.ctrl.alu_op)
            ALU_OP_ADD: alu_res = alu_x + alu_y;
            ALU_OP_SUB: alu_res = alu_x - alu_y;
            ALU_OP_AND: alu_res = alu_x & alu_y;
            ALU_OP_OR:  alu_res = alu_x | alu_y;
            ALU_OP_SLL: alu_res = alu_x << dx_i.shamt;
            ALU_OP_SRA: alu_res = word_t'($signed(alu_x) >>> dx_i.shamt);
            default:    alu_res = '0;
        endcase
    end

    assign ne = (alu_res != '0);
    // signed less-than from the difference, corrected when signs differ
    assign lt = (alu_x[31] ^ alu_y[31]) ? alu_x[31] : alu_res[31];

    always_comb begin
        jump_en_o = 1'b0;
        jump_pc_o = dx_i.target;
        case (dx_i.ctrl.branch)
            BR_J, BR_JAL: jump_en_o = 1'b1;
            BR_JR: begin
                jump_en_o = 1'b1;
                jump_pc_o = b_fwd;           // rd value
            end
            BR_BNE: begin
                jump_en_o = ne;
                jump_pc_o = dx_i.pc + 32'd1 + dx_i.imm;
            end
            BR_BLT: begin
                jump_en_o = lt;
                jump_pc_o = dx_i.pc + 32'd1 + dx_i.imm;
            end
            default: jump_en_o = 1'b0;
        endcase
    end

    assign result = (dx_i.ctrl.branch == BR_JAL) ? dx_i.pc + 32'd1 : alu_res;  // link value

    always_ff @(posedge clock) begin
        if (reset_i) begin
            xm_q <= '0;
        end else begin
            xm_q.pc   <= dx_i.pc;
            xm_q.ctrl <= dx_i.ctrl;
            xm_q.o    <= result;
            xm_q.b    <= b_fwd;
        end
    end

    assign xm_o = xm_q;

endmodule

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
    input  logic           clock,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           jump_en_i,
    input  cpu_pkg::word_t jump_pc_i,
    input  cpu_pkg::word_t instr_i,
    output cpu_pkg::word_t imem_addr_o,
    output cpu_pkg::fd_t   fd_o
);
    import cpu_pkg::*;

    word_t pc_q;
    word_t pc_next;
    fd_t   fd_q;

    // jump has priority over a load-use hold
    always_comb begin
        if (jump_en_i) begin
            pc_next = jump_pc_i;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            pc_q <= '0;
            fd_q <= '0;
        end else begin
            pc_q <= pc_next;
            if (jump_en_i) begin
                fd_q <= '0;                                   // squash fetched word
            end else if (!stall_i) begin
                fd_q <= '{pc: pc_q, instr: instr_i};
            end
        end
    end

    assign imem_addr_o = pc_q;
    assign fd_o        = fd_q;

    a_pc_known: assert property (@(posedge clock) disable iff (reset_i) !$isunknown(pc_q));

endmodule

// ==== memory/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
    input  logic                clock,
    input  logic                reset_i,
    input  cpu_pkg::xm_t        xm_i,
    input  cpu_pkg::wb_t        wb_i,
    input  cpu_pkg::word_t      dmem_rdata_i,
    output cpu_pkg::dmem_req_t  dmem_req_o,
    output cpu_pkg::mw_t        mw_o
);
    import cpu_pkg::*;

    word_t store_data;
    mw_t   mw_q;

    // covers a load directly followed by a store of its result
    assign store_data = (wb_i.we && wb_i.rd == xm_i.ctrl.rd) ? wb_i.data : xm_i.b;

    assign dmem_req_o.addr  = xm_i.o;
    assign dmem_req_o.wdata = store_data;
    assign dmem_req_o.wren  = xm_i.ctrl.is_store;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            mw_q <= '0;
        end else begin
            mw_q.ctrl <= xm_i.ctrl;
            mw_q.o    <= xm_i.o;
            mw_q.d    <= dmem_rdata_i;
        end
    end

    assign mw_o = mw_q;

    // a dmem write is a plain store, never a load or a register write
    a_wren_store: assert property (
        @(posedge clock) disable iff (reset_i)
        dmem_req_o.wren |-> (!xm_i.ctrl.is_load && !xm_i.ctrl.reg_wr)
    );

endmodule

// ==== tb.f ====
+incdir+common
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
design/writeback_regfile.sv
design/cpu_core.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clock_o,
    output logic reset_o
);
    initial begin
        clock_o = 1'b0;
        forever begin
            #5 clock_o = ~clock_o;   // 10 ns period
        end
    end

    // power-on reset for 5 cycles
    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clock_o);
        #1 reset_o = 1'b0;
    end

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_cpu;
    import cpu_pkg::*;

    typedef dmem_req_t req_list_t[$];

    logic      clock;
    logic      por_rst;
    logic      test_rst;
    logic      reset;
    word_t     imem_addr;
    word_t     instr;
    word_t     dmem_rdata;
    dmem_req_t dmem_req;

    word_t     imem [256];
    word_t     dmem [256];
    word_t     mem_init [256];
    word_t     prog [$];
    req_list_t exp_q;
    int        got_count;
    int        err_count;
    int        tests_run;
    int        tests_passed;
    logic      checking;

    tb_clock i_clock (.clock_o(clock), .reset_o(por_rst));

    assign reset = por_rst | test_rst;

    cpu_core i_dut (
        .clock        (clock),
        .reset_i      (reset),
        .instr_i      (instr),
        .dmem_rdata_i (dmem_rdata),
        .imem_addr_o  (imem_addr),
        .dmem_req_o   (dmem_req)
    );

    // imem rom and dmem, both read combinationally
    assign instr      = (imem_addr < 32'd256) ? imem[imem_addr[7:0]] : '0;
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];

    always @(posedge clock) begin
        if (dmem_req.wren) begin
            dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end
    end

    function automatic word_t fill_word(input int i);
        return (word_t'(i) * 32'h9e3779b1) ^ 32'h3c5a0000;
    endfunction

    function automatic word_t enc_r(input logic [4:0] alu, input reg_idx_t rd,
                                    input reg_idx_t rs, input reg_idx_t rt,
                                    input logic [4:0] sh);
        return {`OP_RTYPE, rd, rs, rt, sh, alu, 2'b00};
    endfunction

    function automatic word_t enc_i(input logic [4:0] op, input reg_idx_t rd,
                                    input reg_idx_t rs, input int imm);
        return {op, rd, rs, imm[16:0]};
    endfunction

    function automatic word_t enc_j(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

    // architectural model, one instruction at a time
    function automatic req_list_t run_isa();
        req_list_t stores;
        word_t     regs [32];
        word_t     mem [256];
        word_t     pc;
        word_t     next;
        word_t     w;
        word_t     imm;
        word_t     tgt;
        word_t     addr;
        word_t     val;
        reg_idx_t  rd;
        reg_idx_t  rs;
        reg_idx_t  rt;
        logic [4:0] sh;
        logic      done;
        int        steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = mem_init[i];
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            w    = (pc < 32'd256) ? imem[pc[7:0]] : '0;
            rd   = w[26:22];
            rs   = w[21:17];
            rt   = w[16:12];
            sh   = w[11:7];
            imm  = {{15{w[16]}}, w[16:0]};
            tgt  = {{5{w[26]}}, w[26:0]};
            next = pc + 32'd1;
            addr = regs[rs] + imm;
            case (w[31:27])
                `OP_RTYPE: begin
                    case (w[6:2])
                        `ALU_ADD: val = regs[rs] + regs[rt];
                        `ALU_SUB: val = regs[rs] - regs[rt];
                        `ALU_AND: val = regs[rs] & regs[rt];
                        `ALU_OR:  val = regs[rs] | regs[rt];
                        `ALU_SLL: val = regs[rs] << sh;
                        `ALU_SRA: val = word_t'($signed(regs[rs]) >>> sh);
                        default:  val = '0;
                    endcase
                    regs[rd] = val;
                end
                `OP_ADDI: regs[rd] = regs[rs] + imm;
                `OP_LW:   regs[rd] = mem[addr[7:0]];
                `OP_SW: begin
                    stores.push_back('{addr: addr, wdata: regs[rd], wren: 1'b1});
                    mem[addr[7:0]] = regs[rd];
                end
                `OP_J: begin
                    if (tgt == pc) begin
                        done = 1'b1;   // self loop ends the program
                    end
                    next = tgt;
                end
                `OP_JAL: begin
                    regs[`CPU_LINK_REG] = pc + 32'd1;
                    next = tgt;
                end
                `OP_JR: next = regs[rd];
                `OP_BNE: begin
                    if (regs[rd] != regs[rs]) begin
                        next = pc + 32'd1 + imm;
                    end
                end
                `OP_BLT: begin
                    if ($signed(regs[rd]) < $signed(regs[rs])) begin
                        next = pc + 32'd1 + imm;
                    end
                end
                default: val = '0;
            endcase
            regs[0] = '0;
            pc = next;
            steps++;
        end
        return stores;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_req(input dmem_req_t got, input dmem_req_t exp);
        if (got.addr !== exp.addr) begin
            $display("FAIL dmem_req_o.addr got 0x%h expected 0x%h", got.addr, exp.addr);
            err_count++;
        end
        if (got.wdata !== exp.wdata) begin
            $display("FAIL dmem_req_o.wdata got 0x%h expected 0x%h", got.wdata, exp.wdata);
            err_count++;
        end
    endtask

    // compare each store against the model list
    always @(negedge clock) begin
        if (checking && dmem_req.wren) begin
            if (got_count < exp_q.size()) begin
                check_req(dmem_req, exp_q[got_count]);
            end else begin
                $display("unexpected extra store to address 0x%h", dmem_req.addr);
                err_count++;
            end
            got_count++;
        end
    end

    task automatic run_test(input string name);
        int start_err;
        int cycles;
        start_err = err_count;
        @(posedge clock);
        #1;
        checking = 1'b0;
        test_rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i]     = (i < prog.size()) ? prog[i] : '0;
            dmem[i]     = fill_word(i);
            mem_init[i] = fill_word(i);
        end
        exp_q = run_isa();
        got_count = 0;
        repeat (5) @(posedge clock);
        #1;
        test_rst = 1'b0;
        checking = 1'b1;
        cycles = 0;
        while (got_count < exp_q.size() && cycles < 2000) begin
            @(posedge clock);
            cycles++;
        end
        if (got_count < exp_q.size()) begin
            $display("%s timed out with %0d of %0d stores seen", name, got_count, exp_q.size());
            err_count++;
        end
        cycles = 0;
        while (cycles < 20) begin   // catch stray stores
            @(posedge clock);
            cycles++;
        end
        checking = 1'b0;
        tests_run++;
        if (err_count == start_err) begin
            tests_passed++;
            $display("test %s: passed, %0d stores", name, exp_q.size());
        end else begin
            $display("test %s: failed", name);
        end
    endtask

    task automatic build_random();
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        int       kind;
        int       imm;
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            prog.push_back(enc_i(`OP_ADDI, reg_idx_t'(r), '0, int'($urandom_range(0, 999)) - 500));
        end
        for (int n = 0; n < 40; n++) begin
            kind = int'($urandom_range(0, 8));
            rd   = reg_idx_t'($urandom_range(1, 7));
            rs   = reg_idx_t'($urandom_range(0, 7));
            rt   = reg_idx_t'($urandom_range(0, 7));
            imm  = int'($urandom_range(0, 63)) - 16;
            case (kind)
                0: prog.push_back(enc_r(`ALU_ADD, rd, rs, rt, 5'd0));
                1: prog.push_back(enc_r(`ALU_SUB, rd, rs, rt, 5'd0));
                2: prog.push_back(enc_r(`ALU_AND, rd, rs, rt, 5'd0));
                3: prog.push_back(enc_r(`ALU_OR, rd, rs, rt, 5'd0));
                4: prog.push_back(enc_r(`ALU_SLL, rd, rs, rt, 5'($urandom_range(0, 31))));
                5: prog.push_back(enc_r(`ALU_SRA, rd, rs, rt, 5'($urandom_range(0, 31))));
                6: prog.push_back(enc_i(`OP_ADDI, rd, rs, imm));
                7: prog.push_back(enc_i(`OP_LW, rd, rs, imm));
                default: prog.push_back(enc_i(`OP_SW, rd, rs, imm));
            endcase
        end
        for (int r = 1; r < 8; r++) begin
            prog.push_back(enc_i(`OP_SW, reg_idx_t'(r), '0, 100 + r));
        end
        prog.push_back(enc_j(`OP_J, prog.size()));
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hd6ed));
        test_rst = 1'b0;
        checking = 1'b0;
        err_count = 0;
        tests_run = 0;
        tests_passed = 0;
        got_count = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
            mem_init[i] = fill_word(i);
        end

        // reset: no store while held, fetch starts at 0
        cycles = 0;
        while (por_rst && cycles < 50) begin
            @(negedge clock);
            check_word("dmem_req_o.wren", word_t'(dmem_req.wren), '0);
            cycles++;
        end
        if (por_rst) begin
            $display("power-on reset never released");
            err_count++;
        end
        #2;
        check_word("imem_addr_o", imem_addr, '0);
        tests_run++;
        if (err_count == 0) begin
            tests_passed++;
            $display("test reset: passed");
        end else begin
            $display("test reset: failed");
        end

        prog.delete();
        prog.push_back(enc_i(`OP_ADDI, 5'd1, 5'd0, 5));
        prog.push_back(enc_i(`OP_ADDI, 5'd2, 5'd0, -3));
        prog.push_back(enc_r(`ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(enc_r(`ALU_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        prog.push_back(enc_r(`ALU_AND, 5'd5, 5'd4, 5'd3, 5'd0));
        prog.push_back(enc_r(`ALU_OR, 5'd6, 5'd5, 5'd4, 5'd0));
        prog.push_back(enc_r(`ALU_SLL, 5'd7, 5'd6, 5'd0, 5'd3));
        prog.push_back(enc_r(`ALU_SRA, 5'd8, 5'd7, 5'd0, 5'd1));
        prog.push_back(enc_i(`OP_ADDI, 5'd9, 5'd8, 100));
        for (int r = 3; r < 10; r++) begin
            prog.push_back(enc_i(`OP_SW, reg_idx_t'(r), 5'd0, 7 + r));
        end
        prog.push_back(enc_j(`OP_J, prog.size()));
        run_test("arith");

        prog.delete();
        prog.push_back(enc_i(`OP_LW, 5'd1, 5'd0, 3));
        prog.push_back(enc_r(`ALU_ADD, 5'd2, 5'd1, 5'd1, 5'd0));   // load-use
        prog.push_back(enc_i(`OP_LW, 5'd3, 5'd0, 4));
        prog.push_back(enc_i(`OP_SW, 5'd3, 5'd0, 20));             // store of loaded reg
        prog.push_back(enc_i(`OP_LW, 5'd4, 5'd0, 5));
        prog.push_back(enc_i(`OP_ADDI, 5'd5, 5'd4, 1));
        prog.push_back(enc_i(`OP_SW, 5'd5, 5'd0, 21));
        prog.push_back(enc_i(`OP_LW, 5'd6, 5'd0, 20));
        prog.push_back(enc_i(`OP_SW, 5'd6, 5'd0, 22));
        prog.push_back(enc_i(`OP_ADDI, 5'd8, 5'd0, 30));
        prog.push_back(enc_i(`OP_SW, 5'd8, 5'd0, 6));
        prog.push_back(enc_i(`OP_LW, 5'd9, 5'd0, 6));
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd9, 0));              // loaded base
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd0, 23));
        prog.push_back(enc_j(`OP_J, prog.size()));
        run_test("load_store");

        prog.delete();
        prog.push_back(enc_i(`OP_ADDI, 5'd1, 5'd0, 1));
        prog.push_back(enc_i(`OP_ADDI, 5'd2, 5'd0, 2));
        prog.push_back(enc_i(`OP_BNE, 5'd1, 5'd2, 2));             // taken
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 40));
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd0, 41));
        prog.push_back(enc_i(`OP_BNE, 5'd1, 5'd1, 2));             // not taken
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 42));
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd0, 43));
        prog.push_back(enc_i(`OP_BLT, 5'd1, 5'd2, 2));             // taken
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 44));
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd0, 45));
        prog.push_back(enc_i(`OP_BLT, 5'd2, 5'd1, 2));             // not taken
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 46));
        prog.push_back(enc_i(`OP_SW, 5'd2, 5'd0, 47));
        prog.push_back(enc_i(`OP_ADDI, 5'd3, 5'd0, -1));
        prog.push_back(enc_i(`OP_BLT, 5'd3, 5'd1, 2));             // signed, taken
        prog.push_back(enc_i(`OP_SW, 5'd3, 5'd0, 48));
        prog.push_back(enc_i(`OP_SW, 5'd3, 5'd0, 49));
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 51));
        prog.push_back(enc_j(`OP_J, prog.size()));
        run_test("branches");

        prog.delete();
        prog.push_back(enc_i(`OP_ADDI, 5'd1, 5'd0, 7));
        prog.push_back(enc_j(`OP_JAL, 5));
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 50));
        prog.push_back(enc_i(`OP_SW, 5'd31, 5'd0, 51));
        prog.push_back(enc_j(`OP_J, 9));
        prog.push_back(enc_i(`OP_SW, 5'd31, 5'd0, 52));            // link value
        prog.push_back(enc_i(`OP_ADDI, 5'd1, 5'd1, 1));
        prog.push_back(enc_i(`OP_JR, 5'd31, 5'd0, 0));
        prog.push_back(enc_i(`OP_SW, 5'd1, 5'd0, 53));
        prog.push_back(enc_j(`OP_J, 9));
        run_test("jumps");

        for (int n = 0; n < 8; n++) begin
            build_random();
            run_test($sformatf("random_%0d", n));
        end

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, err_count);
        if (err_count == 0 && tests_passed == tests_run) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
